// ==== build.f ====
cpuPkg.sv
stageIf.sv
instrDecode.sv
aluExecute.sv
resultWriteback.sv
cpuTop.sv
cpuAsserts.sv
cpuTb.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - cpuPkg.sv
  - stageIf.sv
  - instrDecode.sv
  - aluExecute.sv
  - resultWriteback.sv
  - cpuTop.sv
  - target: test
    files:
      - cpuAsserts.sv
      - cpuTb.sv

// ==== cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

  localparam int randCount = 40;
  localparam int readCount = 10;
  // latency probe, dependent chain, random body, read-out
  localparam int progLen = 1 + 7 + randCount + readCount;
  localparam int cycleLimit = 20 * progLen + 50;

  logic clk;
  logic rst;
  logic [15:0] instr;
  logic instrValid;
  logic instrReady;
  logic [15:0] inputPort;
  logic [15:0] outputPort;
  logic outValid;
  logic outReady;
  logic [2:0] flags;

  logic [15:0] lfsr = 16'd55;
  logic [15:0] regModel [8];
  logic [2:0] flagModel;
  logic [15:0] prog [$];
  logic [15:0] inVals [$];
  logic [15:0] expValue [$];
  logic [2:0] expFlags [$];
  int cycleCount;
  int outsSeen;

  cpuTop DUT (.*);

  bind cpuTop cpuAsserts uAsserts (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abortRun(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // fibonacci lfsr with taps 16 14 13 11, stepped once per bit
  function automatic logic [15:0] takeBits(input int n);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      bits = {bits[14:0], lfsr[0]};
    end
    return bits;
  endfunction

  // encode one instruction and step the reference model in program order
  task automatic addInstr(input logic [3:0] op, input logic [2:0] rd, input logic [2:0] rs,
                          input logic [2:0] rt, input logic [2:0] sh, input logic [7:0] imm);
    logic [16:0] wide;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] inVal;
    logic c;
    logic setF;
    logic wr;
    a = regModel[rs];
    b = regModel[rt];
    res = '0;
    inVal = '0;
    c = 1'b0;
    setF = 1'b0;
    wr = 1'b1;
    case (op)
      4'd1:
      begin
        wide = {1'b0, a} + {1'b0, b};
        res = wide[15:0];
        c = wide[16];
        setF = 1'b1;
      end
      4'd2:
      begin
        // borrow when the subtrahend is larger
        res = a - b;
        c = (a < b);
        setF = 1'b1;
      end
      4'd3:
      begin
        res = a & b;
        setF = 1'b1;
      end
      4'd4:
      begin
        res = a | b;
        setF = 1'b1;
      end
      4'd5:
      begin
        res = a << sh;
        c = (sh != 0) ? a[16 - sh] : 1'b0;
        setF = 1'b1;
      end
      4'd6:
      begin
        res = a >> sh;
        c = (sh != 0) ? a[sh - 1] : 1'b0;
        setF = 1'b1;
      end
      4'd7:
        res = {8'h00, imm};
      4'd8:
        res = a;
      4'd9:
      begin
        inVal = takeBits(16);
        res = inVal;
      end
      4'd10:
      begin
        wr = 1'b0;
        expValue.push_back(a);
        expFlags.push_back(flagModel);
      end
      default:
        wr = 1'b0;
    endcase
    if (setF)
      flagModel = {c, res[15], res == 16'h0000};
    if (wr)
      regModel[rd] = res;
    // ldi uses the immediate view of the word
    if (op == 4'd7)
      prog.push_back({op, rd, 1'b0, imm});
    else
      prog.push_back({op, rd, rs, rt, sh});
    inVals.push_back(inVal);
  endtask

  task automatic buildProgram();
    logic [3:0] op;
    logic [2:0] rd;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] sh;
    logic [7:0] imm;
    logic [2:0] lastRd;
    // probe into the empty pipe
    addInstr(4'd10, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00);
    // dependent chain at distance one and two
    addInstr(4'd7, 3'd1, 3'd0, 3'd0, 3'd0, 8'h34);
    addInstr(4'd7, 3'd2, 3'd0, 3'd0, 3'd0, 8'h81);
    addInstr(4'd1, 3'd3, 3'd1, 3'd2, 3'd0, 8'h00);
    addInstr(4'd2, 3'd4, 3'd1, 3'd3, 3'd0, 8'h00);
    addInstr(4'd5, 3'd5, 3'd4, 3'd0, 3'd3, 8'h00);
    addInstr(4'd10, 3'd0, 3'd5, 3'd0, 3'd0, 8'h00);
    addInstr(4'd10, 3'd0, 3'd4, 3'd0, 3'd0, 8'h00);
    lastRd = 3'd5;
    repeat (randCount)
    begin
      op = 4'(takeBits(4) % 11);
      rd = 3'(takeBits(3));
      // half the sources reuse the last destination
      if (takeBits(1) != 0)
        rs = lastRd;
      else
        rs = 3'(takeBits(3));
      rt = 3'(takeBits(3));
      sh = 3'(takeBits(3));
      imm = 8'(takeBits(8));
      addInstr(op, rd, rs, rt, sh, imm);
      lastRd = rd;
    end
    for (int r = 0; r < 8; r++)
      addInstr(4'd10, 3'd0, 3'(r), 3'd0, 3'd0, 8'h00);
    addInstr(4'd10, 3'd0, 3'd1, 3'd0, 3'd0, 8'h00);
    addInstr(4'd10, 3'd0, 3'd2, 3'd0, 3'd0, 8'h00);
  endtask

  // port takes the value on the coming edge
  task automatic checkOut();
    assert (expValue.size() != 0)
      else abortRun("output handshake with no OUT left in the program");
    assert (outputPort === expValue[0])
      else abortRun($sformatf("[FAIL] outputPort = 0x%h, expected 0x%h",
                              outputPort, expValue[0]));
    assert (flags === expFlags[0])
      else abortRun($sformatf("[FAIL] flags = 0x%h, expected 0x%h", flags, expFlags[0]));
    void'(expValue.pop_front());
    void'(expFlags.pop_front());
    outsSeen++;
  endtask

  initial
  begin
    cycleCount = 0;
    forever
    begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount > cycleLimit)
        abortRun("timeout, the program did not drain within the cycle limit");
    end
  end

  initial
  begin
    int idx;
    logic offering;
    logic accepting;
    logic done;
    rst = 1'b1;
    instr = '0;
    instrValid = 1'b0;
    inputPort = '0;
    outReady = 1'b1;
    flagModel = '0;
    outsSeen = 0;
    for (int r = 0; r < 8; r++)
      regModel[r] = '0;
    buildProgram();
    repeat (2) @(negedge clk);
    rst = 1'b0;
    idx = 0;
    offering = 1'b0;
    accepting = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      assert (DUT.uAsserts.failCount == 0)
        else abortRun("a protocol assertion on the DUT ports fired");
      if (accepting)
      begin
        // IN operand must sit on the port when the op leaves decode
        if (prog[idx][15:12] == 4'd9)
          inputPort = inVals[idx];
        idx++;
        offering = 1'b0;
      end
      if (!offering && idx < prog.size())
      begin
        // random gaps only when no offer is waiting
        offering = (idx == 0) || (takeBits(2) != 0);
        instr = prog[idx];
      end
      instrValid = offering;
      // back-pressure once the latency probe is out
      outReady = (outsSeen == 0) || (takeBits(2) != 0);
      #10;
      accepting = instrValid && instrReady;
      if (outValid && outReady)
        checkOut();
      done = (idx + accepting == prog.size()) && (expValue.size() == 0);
    end
    // nothing more may show up on the port
    repeat (5)
    begin
      @(negedge clk);
      instrValid = 1'b0;
      outReady = 1'b1;
      #10;
      assert (!outValid)
        else abortRun("an extra value appeared on the output port");
    end
    if (DUT.uAsserts.failCount == 0
        && DUT.uAsserts.outsTaken == DUT.uAsserts.outsIssued)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
    begin
      $display("protocol assertion fired or OUT handshake count is wrong");
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

// ==== cpuAsserts.sv ====
`timescale 1ns/1ps

module cpuAsserts (
  input logic clk,
  input logic rst,
  input logic [cpuPkg::dataWidth-1:0] instr,
  input logic instrValid,
  input logic instrReady,
  input logic [cpuPkg::dataWidth-1:0] outputPort,
  input logic outValid,
  input logic outReady,
  input logic [cpuPkg::flagCount-1:0] flags
);

  // read by the testbench after each cycle
  int failCount = 0;
  int outsIssued;
  int outsTaken;
  logic outAccept;

  // an OUT taken from the instruction stream
  assign outAccept = instrValid && instrReady
    && (instr[cpuPkg::dataWidth-1 -: cpuPkg::opWidth] == cpuPkg::opOut);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      outsIssued <= 0;
      outsTaken <= 0;
    end
    else
    begin
      if (outAccept)
        outsIssued <= outsIssued + 1;
      if (outValid && outReady)
        outsTaken <= outsTaken + 1;
    end
  end

  // stalled value holds until the port takes it
  stallStable: assert property (@(posedge clk) disable iff (rst)
    outValid && !outReady |=> outValid && $stable(outputPort))
  else
  begin
    failCount++;
    $error("output value changed or dropped during a stall");
  end

  // no accept exactly while the port stalls
  readyFollowsStall: assert property (@(posedge clk) disable iff (rst)
    instrReady == !(outValid && !outReady))
  else
  begin
    failCount++;
    $error("instrReady does not match the output stall");
  end

  // at most three in flight, never more taken than issued
  outCountSane: assert property (@(posedge clk) disable iff (rst)
    outsTaken <= outsIssued && outsIssued - outsTaken <= 3)
  else
  begin
    failCount++;
    $error("OUT values lost or duplicated on the output port");
  end

  resetState: assert property (@(posedge clk)
    $fell(rst) |-> !outValid && instrReady && flags == '0)
  else
  begin
    failCount++;
    $error("state after reset is not clean");
  end

  // three stall-free edges from accept to outValid
  outLatency: assert property (@(posedge clk) disable iff (rst)
    outAccept ##1 instrReady [*2] |=> outValid)
  else
  begin
    failCount++;
    $error("OUT did not reach the port three edges after accept");
  end

endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
  input  logic clk,
  input  logic rst,
  input  logic [cpuPkg::dataWidth-1:0] instr,
  input  logic instrValid,
  output logic instrReady,
  input  logic [cpuPkg::dataWidth-1:0] inputPort,
  output logic [cpuPkg::dataWidth-1:0] outputPort,
  output logic outValid,
  input  logic outReady,
  output logic [cpuPkg::flagCount-1:0] flags
);

  // stage boundaries
  decodeExecIf deIf ();
  execResultIf erIf ();

  // decode, register file and execute register
  instrDecode uDecode (
    .clk        (clk),
    .rst        (rst),
    .instr      (instr),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .inputPort  (inputPort),
    .de         (deIf.src),
    .er         (erIf.wb)
  );

  // forwarding, alu and flags
  aluExecute uExecute (
    .clk   (clk),
    .rst   (rst),
    .de    (deIf.dst),
    .er    (erIf.src),
    .flags (flags)
  );

  // result register and output port
  resultWriteback uWriteback (
    .clk        (clk),
    .rst        (rst),
    .er         (erIf.dst),
    .outputPort (outputPort),
    .outValid   (outValid),
    .outReady   (outReady)
  );

endmodule

// ==== resultWriteback.sv ====
`timescale 1ns/1ps

module resultWriteback (
  input  logic clk,
  input  logic rst,
  execResultIf.dst er,
  output logic [cpuPkg::dataWidth-1:0] outputPort,
  output logic outValid,
  input  logic outReady
);

  logic resValid;
  cpuPkg::opcodeT resOp;
  logic [cpuPkg::regAddrWidth-1:0] resRd;
  logic [cpuPkg::dataWidth-1:0] resValue;
  logic resWrites;

  // result register
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      resValid <= 1'b0;
    else if (!er.hold)
      resValid <= er.valid;
  end

  always_ff @(posedge clk)
  begin
    if (!er.hold && er.valid)
    begin
      resOp <= er.op;
      resRd <= er.rd;
      resValue <= er.value;
      resWrites <= er.writesReg;
    end
  end

  // out ops sit here until the port takes them
  assign outValid = resValid && (resOp == cpuPkg::opOut);
  assign outputPort = resValue;

  // stall everything while the port refuses
  assign er.hold = outValid && !outReady;

  // write-back bus, also the forwarding source
  assign er.wbEn = resValid && resWrites;
  assign er.wbAddr = resRd;
  assign er.wbData = resValue;

endmodule

// ==== aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute (
  input  logic clk,
  input  logic rst,
  decodeExecIf.dst de,
  execResultIf.src er,
  output logic [cpuPkg::flagCount-1:0] flags
);

  logic [cpuPkg::dataWidth-1:0] opA;
  logic [cpuPkg::dataWidth-1:0] opB;
  logic [cpuPkg::dataWidth-1:0] result;
  logic [cpuPkg::dataWidth:0] wide;
  logic [cpuPkg::shamtWidth-1:0] shamt;
  logic [cpuPkg::flagCount-1:0] nextFlags;
  logic carry;
  logic setsFlags;

  // forward from the result stage when it writes our source
  assign opA = (er.wbEn && er.wbAddr == de.rsAddr) ? er.wbData : de.rsVal;
  assign opB = (er.wbEn && er.wbAddr == de.rtAddr) ? er.wbData : de.rtVal;

  assign shamt = de.operand[cpuPkg::shamtWidth-1:0];

  always_comb
  begin
    wide = '0;
    result = '0;
    carry = 1'b0;
    setsFlags = 1'b0;
    case (de.op)
      cpuPkg::opAdd:
      begin
        wide = {1'b0, opA} + {1'b0, opB};
        result = wide[cpuPkg::dataWidth-1:0];
        carry = wide[cpuPkg::dataWidth];
        setsFlags = 1'b1;
      end
      cpuPkg::opSub:
      begin
        // top bit set on borrow
        wide = {1'b0, opA} - {1'b0, opB};
        result = wide[cpuPkg::dataWidth-1:0];
        carry = wide[cpuPkg::dataWidth];
        setsFlags = 1'b1;
      end
      cpuPkg::opAnd:
      begin
        // logic ops clear carry
        result = opA & opB;
        setsFlags = 1'b1;
      end
      cpuPkg::opOr:
      begin
        result = opA | opB;
        setsFlags = 1'b1;
      end
      cpuPkg::opShl:
      begin
        // extra bit on top catches the last bit out
        wide = {1'b0, opA} << shamt;
        result = wide[cpuPkg::dataWidth-1:0];
        carry = wide[cpuPkg::dataWidth];
        setsFlags = 1'b1;
      end
      cpuPkg::opShr:
      begin
        // extra bit at the bottom, zero shift leaves carry clear
        wide = {opA, 1'b0} >> shamt;
        result = wide[cpuPkg::dataWidth:1];
        carry = wide[0];
        setsFlags = 1'b1;
      end
      cpuPkg::opLdi, cpuPkg::opIn:
        result = de.operand;
      cpuPkg::opMov, cpuPkg::opOut:
        result = opA;
      default:
        result = '0;
    endcase
  end

  always_comb
  begin
    nextFlags = '0;
    nextFlags[cpuPkg::flagZero] = (result == '0);
    nextFlags[cpuPkg::flagNeg] = result[cpuPkg::dataWidth-1];
    nextFlags[cpuPkg::flagCarry] = carry;
  end

  // flags move with the op into the result stage
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      flags <= '0;
    else if (!er.hold && de.valid && setsFlags)
      flags <= nextFlags;
  end

  // load values for the result register
  assign er.valid = de.valid;
  assign er.op = de.op;
  assign er.rd = de.rd;
  assign er.value = result;
  assign er.writesReg = de.writesReg;

endmodule

// ==== instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode (
  input  logic clk,
  input  logic rst,
  input  cpuPkg::instrWord instr,
  input  logic instrValid,
  output logic instrReady,
  input  logic [cpuPkg::dataWidth-1:0] inputPort,
  decodeExecIf.src de,
  execResultIf.wb er
);

  cpuPkg::instrWord decInstr;
  logic decValid;
  logic [cpuPkg::dataWidth-1:0] regFile [cpuPkg::regCount];
  cpuPkg::opcodeT op;
  logic [cpuPkg::regAddrWidth-1:0] rd;
  logic [cpuPkg::regAddrWidth-1:0] rsAddr;
  logic [cpuPkg::regAddrWidth-1:0] rtAddr;
  logic [cpuPkg::dataWidth-1:0] rsRead;
  logic [cpuPkg::dataWidth-1:0] rtRead;
  logic [cpuPkg::dataWidth-1:0] operand;
  logic writesReg;

  // no accept while the output port stalls the pipe
  assign instrReady = !er.hold;

  // decode register, a bubble enters when nothing is offered
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      decValid <= 1'b0;
    else if (!er.hold)
      decValid <= instrValid;
  end

  always_ff @(posedge clk)
  begin
    if (!er.hold && instrValid)
      decInstr <= instr;
  end

  // register file, written from the result stage
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < cpuPkg::regCount; i++)
        regFile[i] <= '0;
    end
    else if (er.wbEn)
      regFile[er.wbAddr] <= er.wbData;
  end

  // field decode through the union
  always_comb
  begin
    op = decInstr.rForm.opcode;
    rd = decInstr.rForm.rd;
    rsAddr = decInstr.rForm.rs;
    rtAddr = decInstr.rForm.rt;
    operand = '0;
    writesReg = 1'b0;
    case (op)
      cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opMov:
        writesReg = 1'b1;
      cpuPkg::opShl, cpuPkg::opShr:
      begin
        writesReg = 1'b1;
        operand[cpuPkg::shamtWidth-1:0] = decInstr.rForm.shamt;
      end
      cpuPkg::opLdi:
      begin
        // immediate view, zero-extended
        writesReg = 1'b1;
        rd = decInstr.iForm.rd;
        operand[cpuPkg::immWidth-1:0] = decInstr.iForm.imm;
      end
      cpuPkg::opIn:
      begin
        // port sampled as the op moves to execute
        writesReg = 1'b1;
        operand = inputPort;
      end
      default:
        writesReg = 1'b0;
    endcase
  end

  // write-through, a read of the register being written sees new data
  assign rsRead = (er.wbEn && er.wbAddr == rsAddr) ? er.wbData : regFile[rsAddr];
  assign rtRead = (er.wbEn && er.wbAddr == rtAddr) ? er.wbData : regFile[rtAddr];

  // execute register
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      de.valid <= 1'b0;
    else if (!er.hold)
      de.valid <= decValid;
  end

  always_ff @(posedge clk)
  begin
    if (!er.hold && decValid)
    begin
      de.op <= op;
      de.rd <= rd;
      de.rsAddr <= rsAddr;
      de.rtAddr <= rtAddr;
      de.rsVal <= rsRead;
      de.rtVal <= rtRead;
      de.operand <= operand;
      de.writesReg <= writesReg;
    end
  end

endmodule

// ==== stageIf.sv ====
`timescale 1ns/1ps

// decode to execute boundary, driven by the execute register in decode
interface decodeExecIf;
  logic valid;
  cpuPkg::opcodeT op;
  logic [cpuPkg::regAddrWidth-1:0] rd;
  logic [cpuPkg::regAddrWidth-1:0] rsAddr;
  logic [cpuPkg::regAddrWidth-1:0] rtAddr;
  logic [cpuPkg::dataWidth-1:0] rsVal;
  logic [cpuPkg::dataWidth-1:0] rtVal;
  // immediate, shift amount or sampled input port
  logic [cpuPkg::dataWidth-1:0] operand;
  logic writesReg;

  modport src (output valid, op, rd, rsAddr, rtAddr, rsVal, rtVal, operand, writesReg);
  modport dst (input valid, op, rd, rsAddr, rtAddr, rsVal, rtVal, operand, writesReg);
endinterface

// execute to result boundary, plus hold and write-back flowing back
interface execResultIf;
  logic valid;
  cpuPkg::opcodeT op;
  logic [cpuPkg::regAddrWidth-1:0] rd;
  logic [cpuPkg::dataWidth-1:0] value;
  logic writesReg;
  // from the result stage back to the earlier stages
  logic hold;
  logic wbEn;
  logic [cpuPkg::regAddrWidth-1:0] wbAddr;
  logic [cpuPkg::dataWidth-1:0] wbData;

  modport src (output valid, op, rd, value, writesReg, input hold, wbEn, wbAddr, wbData);
  modport dst (input valid, op, rd, value, writesReg, output hold, wbEn, wbAddr, wbData);
  // decode only sees the stall and the write-back bus
  modport wb (input hold, wbEn, wbAddr, wbData);
endinterface

// ==== cpuPkg.sv ====
package cpuPkg;

  // datapath and register file sizes
  localparam int dataWidth = 16;
  localparam int regCount = 8;
  localparam int regAddrWidth = 3;

  // instruction field widths
  localparam int opWidth = 4;
  localparam int shamtWidth = 3;
  localparam int immWidth = 8;

  // flag vector layout
  localparam int flagCount = 3;
  localparam int flagZero = 0;
  localparam int flagNeg = 1;
  localparam int flagCarry = 2;

  // opcode values, codes 11 to 15 decode as nop
  typedef enum logic [opWidth-1:0] {
    opNop = 4'd0,
    opAdd = 4'd1,
    opSub = 4'd2,
    opAnd = 4'd3,
    opOr  = 4'd4,
    opShl = 4'd5,
    opShr = 4'd6,
    opLdi = 4'd7,
    opMov = 4'd8,
    opIn  = 4'd9,
    opOut = 4'd10
  } opcodeT;

  // register form, used by every op except ldi
  // out sends the register named in rs
  typedef struct packed {
    opcodeT opcode;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [shamtWidth-1:0] shamt;
  } rFormT;

  // immediate form, ldi only
  typedef struct packed {
    opcodeT opcode;
    logic [regAddrWidth-1:0] rd;
    logic pad;
    logic [immWidth-1:0] imm;
  } iFormT;

  // one 16-bit word, two views
  typedef union packed {
    rFormT rForm;
    iFormT iForm;
  } instrWord;

endpackage
